// ==== all.f ====
+incdir+dv
design/isa_pkg.sv
design/exec_ctrl_if.sv
design/exec_result_if.sv
design/reg_file.sv
design/instr_decode.sv
design/alu.sv
design/execute.sv
design/result_stage.sv
design/exec_top.sv
dv/exec_tb.sv

// ==== dv/exec_ref.svh ====
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// One expected outcome per issued instruction
typedef struct packed {
  logic        wr_en;
  logic [2:0]  wr_reg;
  logic [15:0] wr_data;
  logic        is_branch;
  logic        taken;
  logic [15:0] target;
  logic        err;
} exp_t;

logic [15:0] shadow [8] = '{default: '0};  // Register state as the model sees it

function automatic logic [15:0] rot_left(input logic [15:0] v, input logic [3:0] n);
  if (n == 4'd0) return v;
  return (v << n) | (v >> (16 - n));
endfunction

function automatic logic [15:0] rot_right(input logic [15:0] v, input logic [3:0] n);
  if (n == 4'd0) return v;
  return (v >> n) | (v << (16 - n));
endfunction

function automatic int sx(input logic [15:0] v);
  return int'($signed(v));
endfunction

// Outside the signed 16-bit range
function automatic logic out_of_range(input int v);
  return (v > 32767) || (v < -32768);
endfunction

// Shadow registers update in issue order
task automatic model_issue(input logic [15:0] w, input logic [15:0] pc_v, output exp_t e);
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] imm5_s;
  logic [15:0] imm5_z;
  logic [15:0] imm8_s;
  logic [15:0] res;
  logic [16:0] wide;
  int          sum;
  a      = shadow[w[10:8]];  // Rs
  b      = shadow[w[7:5]];   // Rt
  imm5_s = {{11{w[4]}}, w[4:0]};
  imm5_z = {11'b0, w[4:0]};
  imm8_s = {{8{w[7]}}, w[7:0]};
  e = '0;
  e.wr_en  = 1'b1;
  e.wr_reg = w[7:5];          // I-format Rd
  e.target = pc_v + imm8_s;   // Wraps
  res = '0;
  sum = 0;
  case (w[15:11])
    OP_ADDI, OP_SUBI: begin
      sum   = (w[11] ? sx(imm5_s) - sx(a) : sx(a) + sx(imm5_s));
      res   = sum[15:0];
      e.err = out_of_range(sum);
    end
    OP_XORI:  res = a ^ imm5_z;
    OP_ANDNI: res = a & ~imm5_z;
    OP_ROLI:  res = rot_left(a, w[3:0]);
    OP_SLLI:  res = a << w[3:0];
    OP_RORI:  res = rot_right(a, w[3:0]);
    OP_SRLI:  res = a >> w[3:0];
    OP_RTYPE_ARITH: begin
      e.wr_reg = w[4:2];
      case (w[1:0])
        2'd0:    sum = sx(a) + sx(b);
        2'd1:    sum = sx(b) - sx(a);  // Rt - Rs
        2'd2:    sum = int'(a ^ b);
        default: sum = int'(a & ~b);
      endcase
      res   = sum[15:0];
      e.err = !w[1] && out_of_range(sum);
    end
    OP_RTYPE_SHIFT: begin
      e.wr_reg = w[4:2];
      case (w[1:0])
        2'd0:    res = rot_left(a, b[3:0]);
        2'd1:    res = a << b[3:0];
        2'd2:    res = rot_right(a, b[3:0]);
        default: res = a >> b[3:0];
      endcase
    end
    OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
      e.wr_reg = w[4:2];
      wide = {1'b0, a} + {1'b0, b};
      case (w[12:11])
        2'd0:    res = {15'b0, a == b};
        2'd1:    res = {15'b0, $signed(a) < $signed(b)};
        2'd2:    res = {15'b0, $signed(a) <= $signed(b)};
        default: res = {15'b0, wide[16]};  // Unsigned carry out
      endcase
    end
    OP_LBI: begin
      e.wr_reg = w[10:8];
      res      = imm8_s;
    end
    OP_SLBI: begin
      e.wr_reg = w[10:8];
      res      = {a[7:0], w[7:0]};
    end
    OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
      e.wr_en     = 1'b0;
      e.is_branch = 1'b1;
      case (w[12:11])
        2'd0:    e.taken = (a == '0);
        2'd1:    e.taken = (a != '0);
        2'd2:    e.taken = a[15];
        default: e.taken = !a[15];
      endcase
    end
    default: e.wr_en = 1'b0;
  endcase
  e.wr_data = res;
  if (e.wr_en) begin
    shadow[e.wr_reg] = res;
  end
endtask

`endif

// ==== dv/exec_tb.sv ====
`timescale 1ns/1ns

module exec_tb import isa_pkg::*; ();

  localparam int TO_MULT  = 4;   // Cycles allowed per issued instruction
  localparam int TO_SLACK = 50;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [15:0] instr;
  logic [15:0] pc;
  logic        result_valid;
  logic        wr_en;
  logic [2:0]  wr_reg;
  logic [15:0] wr_data;
  logic        branch_taken;
  logic [15:0] branch_target;
  logic        err;

  int seed       = 32'h6bbf4f55;
  int issued     = 0;
  int checked    = 0;
  int cycles     = 0;
  int val_errs   = 0;
  int proto_errs = 0;

  `include "exec_ref.svh"

  exp_t  exp_q [$];   // Expected outcomes, oldest first
  string name_q [$];  // Test name per outcome

  exec_top i_exec_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .pc            (pc),
    .result_valid  (result_valid),
    .wr_en         (wr_en),
    .wr_reg        (wr_reg),
    .wr_data       (wr_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .err           (err)
  );

  always #4 clk = ~clk;

  // Result shows up exactly two cycles after issue, never otherwise
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid == $past(instr_valid, 2))
    else begin
      proto_errs++;
      $display("result_valid did not follow instr_valid by two cycles at %0t", $time);
    end

  // Quiet outputs whenever no result is presented
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !result_valid |-> !(wr_en || branch_taken || err))
    else begin
      proto_errs++;
      $display("wr_en, branch_taken or err high without result_valid at %0t", $time);
    end

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [15:0] enc_i(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rd, input logic [4:0] imm);
    return {op, rs, rd, imm};
  endfunction

  function automatic logic [15:0] enc_r(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [2:0] rd,
                                        input logic [1:0] fn);
    return {op, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] enc_b(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [7:0] imm);
    return {op, rs, imm};
  endfunction

  task automatic check_field(input string test, input string field,
                             input logic [15:0] exp_v, input logic [15:0] act_v);
    assert (act_v === exp_v) else begin
      val_errs++;
      $display("ERR %s %s: expected %h actual %h at %0t", test, field, exp_v, act_v, $time);
    end
  endtask

  // One instruction per call, back to back when called in a row
  task automatic issue(input string name, input logic [15:0] w);
    exp_t        e;
    logic [15:0] p;
    p = 16'($random(seed));
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    pc          <= p;
    model_issue(w, p, e);
    exp_q.push_back(e);
    name_q.push_back(name);
    issued++;
  endtask

  // LBI gives the upper byte, SLBI shifts it up and adds the lower
  task automatic load_const(input string name, input logic [2:0] r, input logic [15:0] v);
    issue(name, enc_b(OP_LBI, r, v[15:8]));
    issue(name, enc_b(OP_SLBI, r, v[7:0]));
  endtask

  task automatic random_arith(input int n);
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    load_const("arith", 3'd1, 16'h8000);
    load_const("arith", 3'd2, 16'h7fff);
    issue("arith", enc_i(OP_SUBI, 3'd1, 3'd3, 5'd0));  // 0 - (-32768) overflows
    issue("arith", enc_i(OP_ADDI, 3'd2, 3'd4, 5'd1));
    issue("arith", enc_r(OP_RTYPE_ARITH, 3'd1, 3'd1, 3'd5, FN_ADD));
    issue("arith", enc_r(OP_RTYPE_ARITH, 3'd2, 3'd1, 3'd6, FN_SUB));
    issue("arith", enc_r(OP_RTYPE_ARITH, 3'd2, 3'd1, 3'd7, FN_ADD));  // -1, no overflow
    for (int i = 0; i < n; i++) begin
      rs = 3'(rnd(8));
      rt = 3'(rnd(8));
      rd = 3'(rnd(8));
      case (rnd(3))
        0:       load_const("arith", rd, 16'($random(seed)));
        1:       issue("arith", enc_i({3'b010, 2'(rnd(4))}, rs, rd, 5'(rnd(32))));
        default: issue("arith", enc_r(OP_RTYPE_ARITH, rs, rt, rd, 2'(rnd(4))));
      endcase
    end
  endtask

  task automatic shift_sweep();
    for (int amt = 0; amt < 16; amt++) begin
      load_const("shift", 3'd1, 16'($random(seed)));
      for (int k = 0; k < 4; k++) begin
        issue("shift", enc_i({3'b101, 2'(k)}, 3'd1, 3'(k + 2), {1'(rnd(2)), 4'(amt)}));
      end
      load_const("shift", 3'd6, {12'($random(seed)), 4'(amt)});  // Upper bits ignored
      for (int k = 0; k < 4; k++) begin
        issue("shift", enc_r(OP_RTYPE_SHIFT, 3'd1, 3'd6, 3'(k + 2), 2'(k)));
      end
    end
  endtask

  task automatic set_compares(input int n);
    logic [2:0] rs;
    logic [2:0] rt;
    for (int i = 0; i < n; i++) begin
      rs = 3'(rnd(8));
      rt = (rnd(4) == 0) ? rs : 3'(rnd(8));  // Equal operands now and then
      load_const("set", 3'(rnd(8)), 16'($random(seed)));
      issue("set", enc_r({3'b111, 2'(rnd(4))}, rs, rt, 3'(rnd(8)), 2'b00));
    end
  endtask

  task automatic branch_mix(input int n);
    logic [2:0] r;
    for (int i = 0; i < n; i++) begin
      r = 3'(rnd(8));
      load_const("branch", r, (rnd(3) == 0) ? 16'h0000 : 16'($random(seed)));
      issue("branch", enc_b({3'b011, 2'(rnd(4))}, r, 8'($random(seed))));
    end
  endtask

  // Each instruction reads what the one before it wrote
  task automatic dependent_chain(input int n);
    logic [2:0] last;
    logic [2:0] rd;
    last = 3'd3;
    load_const("chain", last, 16'($random(seed)));
    for (int i = 0; i < n; i++) begin
      rd = 3'(rnd(8));
      case (rnd(4))
        0:       issue("chain", enc_i({3'b010, 2'(rnd(4))}, last, rd, 5'(rnd(32))));
        1:       issue("chain", enc_r(OP_RTYPE_ARITH, last, 3'(rnd(8)), rd, 2'(rnd(4))));
        2:       issue("chain", enc_r(OP_RTYPE_SHIFT, last, 3'(rnd(8)), rd, 2'(rnd(4))));
        default: begin
          rd = last;
          issue("chain", enc_b(OP_SLBI, last, 8'($random(seed))));
        end
      endcase
      last = rd;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    exp_t  e;
    string nm;
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("result_valid high with no instruction outstanding at %0t", $time);
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        checked++;
        check_field(nm, "wr_en", 16'(e.wr_en), 16'(wr_en));
        check_field(nm, "err", 16'(e.err), 16'(err));
        check_field(nm, "branch_taken", 16'(e.taken), 16'(branch_taken));
        if (e.wr_en) begin
          check_field(nm, "wr_reg", 16'(e.wr_reg), 16'(wr_reg));
          check_field(nm, "wr_data", e.wr_data, wr_data);
        end
        if (e.is_branch) begin
          check_field(nm, "branch_target", e.target, branch_target);
        end
      end
    end
  end

  initial begin
    while (cycles <= TO_MULT * issued + TO_SLACK) begin
      @(posedge clk);
      cycles++;
    end
    $display("Cycle limit reached after %0d cycles, %0d results outstanding",
             cycles, exp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);  // Idle outputs after reset
    for (int r = 0; r < 8; r++) begin
      issue("reset_zero", enc_i(OP_ADDI, 3'(r), 3'(r), 5'd0));
    end
    for (int r = 0; r < 8; r++) begin
      load_const("load", 3'(r), 16'($random(seed)));
    end
    random_arith(60);
    shift_sweep();
    set_compares(40);
    branch_mix(40);
    dependent_chain(50);
    @(posedge clk);
    instr_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("Checked %0d results: %0d value errors, %0d protocol errors",
             checked, val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/1ns

module exec_top import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  logic [DATA_W-1:0] instr,
  input  logic [DATA_W-1:0] pc,
  output logic              result_valid,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_reg,
  output logic [DATA_W-1:0] wr_data,
  output logic              branch_taken,
  output logic [DATA_W-1:0] branch_target,
  output logic              err
);

  logic [REG_AW-1:0] rd_addr_a;
  logic [REG_AW-1:0] rd_addr_b;
  logic [DATA_W-1:0] rd_data_a;
  logic [DATA_W-1:0] rd_data_b;
  logic              rf_wr_en;    // Writeback from the result stage
  logic [REG_AW-1:0] rf_wr_addr;
  logic [DATA_W-1:0] rf_wr_data;

  exec_ctrl_if   ctrl_if ();
  exec_result_if res_if ();

  instr_decode i_instr_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .ctrl        (ctrl_if)
  );

  reg_file i_reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .wr_en     (rf_wr_en),
    .wr_addr   (rf_wr_addr),
    .wr_data   (rf_wr_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  execute i_execute (
    .ctrl (ctrl_if),
    .res  (res_if)
  );

  result_stage i_result_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .res           (res_if),
    .rf_wr_en      (rf_wr_en),
    .rf_wr_addr    (rf_wr_addr),
    .rf_wr_data    (rf_wr_data),
    .result_valid  (result_valid),
    .wr_en         (wr_en),
    .wr_reg        (wr_reg),
    .wr_data       (wr_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .err           (err)
  );

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ns

module result_stage import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  exec_result_if.result     res,
  output logic              rf_wr_en,
  output logic [REG_AW-1:0] rf_wr_addr,
  output logic [DATA_W-1:0] rf_wr_data,
  output logic              result_valid,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_reg,
  output logic [DATA_W-1:0] wr_data,
  output logic              branch_taken,
  output logic [DATA_W-1:0] branch_target,
  output logic              err
);

  logic rs_zero;
  logic rs_neg;
  logic cond_met;

  // Branches carry Rs on alu_result
  assign rs_zero = (res.alu_result == '0);
  assign rs_neg  = res.alu_result[DATA_W-1];

  always_comb begin
    case (res.branch_cond)
      BR_EQZ:  cond_met = rs_zero;
      BR_NEZ:  cond_met = ~rs_zero;
      BR_LTZ:  cond_met = rs_neg;
      BR_GEZ:  cond_met = ~rs_neg;
      default: cond_met = 1'b0;  // Not a branch
    endcase
  end

  // Write port lands at the same edge as the outputs below
  assign rf_wr_en   = res.valid & res.wr_en;
  assign rf_wr_addr = res.wr_reg;
  assign rf_wr_data = res.alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      wr_en        <= 1'b0;
      branch_taken <= 1'b0;
      err          <= 1'b0;
    end else begin
      result_valid <= res.valid;
      wr_en        <= rf_wr_en;
      branch_taken <= res.valid & cond_met;
      err          <= res.valid & res.ovf_err;
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid) begin
      wr_reg        <= res.wr_reg;
      wr_data       <= res.alu_result;
      branch_target <= res.branch_target;
    end
  end

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ns

module execute import isa_pkg::*; (
  exec_ctrl_if.execute   ctrl,
  exec_result_if.execute res
);

  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_b;
  logic              is_ror;
  alu_op_e           alu_op;
  logic [DATA_W-1:0] alu_res;
  logic              alu_ovf;
  logic              alu_carry;
  logic              alu_zero;
  logic              alu_ltz;
  logic              set_bit;
  logic [DATA_W-1:0] result;

  // SLBI moves the old low byte up before the new byte is merged in
  assign op_a = ctrl.is_slbi ? (ctrl.rs_data << BYTE_W) : ctrl.rs_data;
  assign op_b = ctrl.alu_src ? ctrl.imm : ctrl.rt_data;

  // Rotate right by n is rotate left by 16 - n, only the low 4 bits matter
  assign is_ror = (ctrl.alu_op == ALU_ROR);
  assign alu_b  = is_ror ? (~op_b + 1'b1) : op_b;
  assign alu_op = is_ror ? ALU_ROL : ctrl.alu_op;

  alu i_alu (
    .a         (op_a),
    .b         (alu_b),
    .op        (alu_op),
    .inv_a     (ctrl.inv_a),
    .inv_b     (ctrl.inv_b),
    .cin       (ctrl.cin),
    .is_signed (ctrl.is_signed),
    .result    (alu_res),
    .ovf       (alu_ovf),
    .carry     (alu_carry),
    .zero      (alu_zero),
    .ltz       (alu_ltz)
  );

  // ALU holds Rt - Rs for the compares, Rs + Rt for SCO
  always_comb begin
    case (ctrl.set_cond)
      SC_EQ:   set_bit = alu_zero;              // Rs == Rt
      SC_LT:   set_bit = ~alu_zero & ~alu_ltz;  // Rt - Rs strictly positive
      SC_LE:   set_bit = ~alu_ltz;              // Rs <= Rt
      default: set_bit = alu_carry;             // SCO
    endcase
  end

  always_comb begin
    if (ctrl.is_set) begin
      result = {{(DATA_W-1){1'b0}}, set_bit};
    end else if (ctrl.is_slbi) begin
      result = op_a | op_b;  // Byte lanes do not overlap
    end else if (ctrl.pass_a) begin
      result = ctrl.rs_data;
    end else if (ctrl.pass_b) begin
      result = op_b;
    end else begin
      result = alu_res;
    end
  end

  assign res.valid         = ctrl.valid;
  assign res.alu_result    = result;
  assign res.branch_target = ctrl.pc + ctrl.imm;     // Wraps at 16 bits
  assign res.ovf_err       = ctrl.is_signed & alu_ovf;  // Only signed add/sub set is_signed
  assign res.branch_cond   = ctrl.branch_cond;
  assign res.wr_en         = ctrl.wr_en;
  assign res.wr_reg        = ctrl.wr_reg;

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu import isa_pkg::*; (
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  alu_op_e           op,
  input  logic              inv_a,
  input  logic              inv_b,
  input  logic              cin,
  input  logic              is_signed,
  output logic [DATA_W-1:0] result,
  output logic              ovf,
  output logic              carry,
  output logic              zero,
  output logic              ltz
);

  logic [DATA_W-1:0]   op_a;
  logic [DATA_W-1:0]   op_b;
  logic [3:0]          amt;       // Shift and rotate distance
  logic [2*DATA_W-1:0] rol_ext;
  logic [DATA_W:0]     sum_ext;
  logic [DATA_W-1:0]   sum;
  logic                s_ovf;     // Two's complement overflow of the add
  logic                is_add;

  // Optional inversions come first
  assign op_a = inv_a ? ~a : a;
  assign op_b = inv_b ? ~b : b;
  assign amt  = op_b[3:0];

  // Rotate left by shifting a doubled copy, upper half is the answer
  assign rol_ext = {op_a, op_a} << amt;

  assign sum_ext = {1'b0, op_a} + {1'b0, op_b} + {{DATA_W{1'b0}}, cin};
  assign sum     = sum_ext[DATA_W-1:0];
  assign carry   = sum_ext[DATA_W];  // Unsigned carry out

  // Same input signs, different result sign
  assign s_ovf = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (sum[DATA_W-1] != op_a[DATA_W-1]);

  assign is_add = (op == ALU_ADD) || (op == ALU_SUB_UNUSED);

  always_comb begin
    case (op)
      ALU_ROL:  result = rol_ext[2*DATA_W-1:DATA_W];
      ALU_SLL:  result = op_a << amt;
      ALU_SRL:  result = op_a >> amt;   // Logical, zero fill
      ALU_XOR:  result = op_a ^ op_b;
      ALU_ANDN: result = op_a & op_b;   // The NOT is applied through inv_b
      default:  result = sum;           // Add and the spare codes
    endcase
  end

  // Overflow only means something for the adder
  assign ovf = is_add & (is_signed ? s_ovf : carry);

  assign zero = (result == '0);

  // True sign of a difference even when the add overflows
  assign ltz = is_add ? (sum[DATA_W-1] ^ s_ovf) : result[DATA_W-1];

endmodule

// ==== design/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  logic [DATA_W-1:0] instr,
  input  logic [DATA_W-1:0] pc,
  input  logic [DATA_W-1:0] rd_data_a,
  input  logic [DATA_W-1:0] rd_data_b,
  output logic [REG_AW-1:0] rd_addr_a,
  output logic [REG_AW-1:0] rd_addr_b,
  exec_ctrl_if.decode       ctrl
);

  opcode_e           opcode;
  func_e             func;
  logic [REG_AW-1:0] rd_i;       // I-format destination
  logic [REG_AW-1:0] rd_r;       // R-format destination
  logic [DATA_W-1:0] imm5_s;
  logic [DATA_W-1:0] imm5_z;
  logic [DATA_W-1:0] imm8_s;
  logic [DATA_W-1:0] imm8_z;
  alu_op_e           n_alu_op;
  logic              n_alu_src;
  logic              n_inv_a;
  logic              n_inv_b;
  logic              n_cin;
  logic              n_signed;
  logic              n_pass_a;
  logic              n_pass_b;
  logic              n_is_set;
  logic              n_is_slbi;
  branch_cond_e      n_br;
  logic [DATA_W-1:0] n_imm;
  logic              n_wr_en;
  logic [REG_AW-1:0] n_wr_reg;

  assign opcode    = opcode_e'(instr[DATA_W-1 -: OPC_W]);
  assign func      = func_e'(instr[1:0]);
  assign rd_addr_a = instr[10:8];  // Rs
  assign rd_addr_b = instr[7:5];   // Rt
  assign rd_i      = instr[7:5];
  assign rd_r      = instr[4:2];

  assign imm5_s = {{(DATA_W-5){instr[4]}}, instr[4:0]};
  assign imm5_z = {{(DATA_W-5){1'b0}}, instr[4:0]};
  assign imm8_s = {{(DATA_W-BYTE_W){instr[BYTE_W-1]}}, instr[BYTE_W-1:0]};
  assign imm8_z = {{(DATA_W-BYTE_W){1'b0}}, instr[BYTE_W-1:0]};

  always_comb begin
    n_alu_op  = alu_op_e'({1'b1, instr[12:11]});  // Arithmetic group by default
    n_alu_src = 1'b0;
    n_inv_a   = 1'b0;
    n_inv_b   = 1'b0;
    n_cin     = 1'b0;
    n_signed  = 1'b0;
    n_pass_a  = 1'b0;
    n_pass_b  = 1'b0;
    n_is_set  = 1'b0;
    n_is_slbi = 1'b0;
    n_br      = BR_NONE;
    n_imm     = imm5_z;
    n_wr_en   = 1'b1;
    n_wr_reg  = rd_r;
    case (opcode)
      OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
        n_alu_src = 1'b1;
        n_wr_reg  = rd_i;
        if (opcode == OP_ADDI || opcode == OP_SUBI) begin
          n_alu_op = ALU_ADD;
          n_signed = 1'b1;
          n_imm    = imm5_s;
        end
        n_inv_a = (opcode == OP_SUBI);  // imm - Rs
        n_cin   = (opcode == OP_SUBI);
        n_inv_b = (opcode == OP_ANDNI);
      end
      OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
        n_alu_op  = alu_op_e'({1'b0, instr[12:11]});
        n_alu_src = 1'b1;
        n_wr_reg  = rd_i;
      end
      OP_RTYPE_ARITH: begin
        n_alu_op = (func == FN_SUB) ? ALU_ADD : alu_op_e'({1'b1, func});
        n_inv_a  = (func == FN_SUB);   // Rt - Rs
        n_cin    = (func == FN_SUB);
        n_inv_b  = (func == FN_ANDN);
        n_signed = (func == FN_ADD) || (func == FN_SUB);
      end
      OP_RTYPE_SHIFT: n_alu_op = alu_op_e'({1'b0, func});
      OP_SEQ, OP_SLT, OP_SLE: begin
        n_alu_op = ALU_ADD;
        n_inv_a  = 1'b1;  // Compare through Rt - Rs
        n_cin    = 1'b1;
        n_is_set = 1'b1;
      end
      OP_SCO: begin
        n_alu_op = ALU_ADD;  // Carry of Rs + Rt
        n_is_set = 1'b1;
      end
      OP_LBI: begin
        n_alu_src = 1'b1;
        n_pass_b  = 1'b1;
        n_imm     = imm8_s;
        n_wr_reg  = rd_addr_a;
      end
      OP_SLBI: begin
        n_alu_src = 1'b1;
        n_is_slbi = 1'b1;
        n_imm     = imm8_z;
        n_wr_reg  = rd_addr_a;
      end
      OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
        n_pass_a = 1'b1;  // Rs goes on to the condition check
        n_imm    = imm8_s;
        n_wr_en  = 1'b0;
        n_wr_reg = NOP_REG;
        n_br     = branch_cond_e'({1'b0, instr[12:11]} + 3'd1);
      end
      default: begin
        n_wr_en  = 1'b0;  // Unsupported opcode passes as a bubble
        n_wr_reg = NOP_REG;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.valid <= 1'b0;
      ctrl.wr_en <= 1'b0;
    end else begin
      ctrl.valid <= instr_valid;
      ctrl.wr_en <= instr_valid & n_wr_en;
    end
  end

  // Payload held between instructions
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      ctrl.alu_op      <= n_alu_op;
      ctrl.alu_src     <= n_alu_src;
      ctrl.inv_a       <= n_inv_a;
      ctrl.inv_b       <= n_inv_b;
      ctrl.cin         <= n_cin;
      ctrl.is_signed   <= n_signed;
      ctrl.pass_a      <= n_pass_a;
      ctrl.pass_b      <= n_pass_b;
      ctrl.is_set      <= n_is_set;
      ctrl.set_cond    <= set_cond_e'(instr[12:11]);
      ctrl.is_slbi     <= n_is_slbi;
      ctrl.branch_cond <= n_br;
      ctrl.rs_data     <= rd_data_a;
      ctrl.rt_data     <= rd_data_b;
      ctrl.imm         <= n_imm;
      ctrl.pc          <= pc;
      ctrl.wr_reg      <= n_wr_reg;
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] rd_addr_a,
  input  logic [REG_AW-1:0] rd_addr_b,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] rd_data_a,
  output logic [DATA_W-1:0] rd_data_b
);

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic              byp_a;
  logic              byp_b;

  // All registers start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write is forwarded so a dependent decode sees it
  assign byp_a = wr_en && (wr_addr == rd_addr_a);
  assign byp_b = wr_en && (wr_addr == rd_addr_b);

  assign rd_data_a = byp_a ? wr_data : regs[rd_addr_a];  // Port A, Rs
  assign rd_data_b = byp_b ? wr_data : regs[rd_addr_b];  // Port B, Rt

endmodule

// ==== design/exec_result_if.sv ====
`timescale 1ns/1ns

// Execute to result stage, purely combinational path
interface exec_result_if import isa_pkg::*; ();

  logic              valid;
  logic [DATA_W-1:0] alu_result;     // Also carries Rs for branches
  logic [DATA_W-1:0] branch_target;
  logic              ovf_err;
  branch_cond_e      branch_cond;
  logic              wr_en;
  logic [REG_AW-1:0] wr_reg;

  modport execute (
    output valid, alu_result, branch_target, ovf_err, branch_cond, wr_en, wr_reg
  );

  modport result (
    input valid, alu_result, branch_target, ovf_err, branch_cond, wr_en, wr_reg
  );

endinterface

// ==== design/exec_ctrl_if.sv ====
`timescale 1ns/1ns

// Decode to execute bundle, registered in decode
interface exec_ctrl_if import isa_pkg::*; ();

  logic              valid;
  alu_op_e           alu_op;
  logic              alu_src;      // 1 selects imm as operand B
  logic              inv_a;
  logic              inv_b;
  logic              cin;
  logic              is_signed;    // Signed add/sub, overflow is an error
  logic              pass_a;       // Result is Rs as read
  logic              pass_b;       // Result is operand B
  logic              is_set;
  set_cond_e         set_cond;
  logic              is_slbi;
  branch_cond_e      branch_cond;
  logic [DATA_W-1:0] rs_data;
  logic [DATA_W-1:0] rt_data;
  logic [DATA_W-1:0] imm;          // Already extended
  logic [DATA_W-1:0] pc;
  logic              wr_en;
  logic [REG_AW-1:0] wr_reg;

  modport decode (
    output valid, alu_op, alu_src, inv_a, inv_b, cin, is_signed, pass_a, pass_b,
    output is_set, set_cond, is_slbi, branch_cond, rs_data, rt_data, imm, pc,
    output wr_en, wr_reg
  );

  modport execute (
    input valid, alu_op, alu_src, inv_a, inv_b, cin, is_signed, pass_a, pass_b,
    input is_set, set_cond, is_slbi, branch_cond, rs_data, rt_data, imm, pc,
    input wr_en, wr_reg
  );

endinterface

// ==== design/isa_pkg.sv ====
package isa_pkg;

  localparam int DATA_W   = 16;           // Datapath width
  localparam int REG_AW   = 3;            // Register index width
  localparam int NUM_REGS = 1 << REG_AW;  // Eight general registers
  localparam int OPC_W    = 5;            // Major opcode field
  localparam int BYTE_W   = 8;            // imm8 width and SLBI shift distance

  // Major opcodes in instr[15:11]
  typedef enum logic [OPC_W-1:0] {
    OP_ADDI        = 5'b01000,
    OP_SUBI        = 5'b01001,
    OP_XORI        = 5'b01010,
    OP_ANDNI       = 5'b01011,
    OP_BEQZ        = 5'b01100,
    OP_BNEZ        = 5'b01101,
    OP_BLTZ        = 5'b01110,
    OP_BGEZ        = 5'b01111,
    OP_SLBI        = 5'b10010,
    OP_ROLI        = 5'b10100,
    OP_SLLI        = 5'b10101,
    OP_RORI        = 5'b10110,
    OP_SRLI        = 5'b10111,
    OP_LBI         = 5'b11000,
    OP_RTYPE_SHIFT = 5'b11010,
    OP_RTYPE_ARITH = 5'b11011,
    OP_SEQ         = 5'b11100,
    OP_SLT         = 5'b11101,
    OP_SLE         = 5'b11110,
    OP_SCO         = 5'b11111
  } opcode_e;

  // R-type function field, instr[1:0]
  // Shift group uses the same slots as ROL, SLL, ROR, SRL
  typedef enum logic [1:0] {
    FN_ADD  = 2'b00,
    FN_SUB  = 2'b01,
    FN_XOR  = 2'b10,
    FN_ANDN = 2'b11
  } func_e;

  // Low two bits line up with the opcode and func fields
  typedef enum logic [2:0] {
    ALU_ROL        = 3'b000,
    ALU_SLL        = 3'b001,
    ALU_ROR        = 3'b010,  // Turned into ROL by execute
    ALU_SRL        = 3'b011,
    ALU_ADD        = 3'b100,
    ALU_SUB_UNUSED = 3'b101,  // Subtract is ADD with inv_a and cin
    ALU_XOR        = 3'b110,
    ALU_ANDN       = 3'b111
  } alu_op_e;

  // Set-on-condition kind, low opcode bits
  typedef enum logic [1:0] {
    SC_EQ = 2'b00,
    SC_LT = 2'b01,
    SC_LE = 2'b10,
    SC_CO = 2'b11
  } set_cond_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQZ,
    BR_NEZ,
    BR_LTZ,
    BR_GEZ
  } branch_cond_e;

  localparam logic [REG_AW-1:0] NOP_REG = '0;  // Destination when nothing is written

endpackage
